//--- Makefile
# Verilator build and run of the data memory testbench

VERILATOR ?= verilator
TOP       ?= tb_data_mem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- data_mem_subsystem.sv
// Data memory subsystem top
`timescale 1ns/1ps
`default_nettype none

module data_mem_subsystem (
    input  logic              clk,
    input  logic              rst_n,
    // Wishbone data port
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  wb_pkg::wb_addr_t  adr_i,
    input  wb_pkg::wb_data_t  dat_i,
    input  wb_pkg::wb_sel_t   sel_i,
    output logic              ack_o,
    output logic              err_o,
    output wb_pkg::wb_data_t  dat_o,
    // Window bases, change only with cyc_i low
    input  wb_pkg::wb_addr_t  region0_base_i,
    input  wb_pkg::wb_addr_t  region1_base_i
);
    import wb_pkg::*;
    import mem_map_pkg::*;

    // ==============================
    // Internal nets
    // ==============================
    logic     r0_stb;
    logic     r1_stb;
    logic     r_we;
    wb_addr_t r_word_adr;   // Shared local word address
    wb_data_t r_dat;
    wb_sel_t  r_sel;
    logic     dec_err;
    logic     r0_ack;
    logic     r1_ack;
    wb_data_t r0_rdata;
    wb_data_t r1_rdata;

    // Request split by address
    region_decoder u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .cyc_i          (cyc_i),
        .stb_i          (stb_i),
        .we_i           (we_i),
        .adr_i          (adr_i),
        .dat_i          (dat_i),
        .sel_i          (sel_i),
        .region0_base_i (region0_base_i),
        .region1_base_i (region1_base_i),
        .r0_stb_o       (r0_stb),
        .r1_stb_o       (r1_stb),
        .r_we_o         (r_we),
        .r_word_adr_o   (r_word_adr),
        .r_dat_o        (r_dat),
        .r_sel_o        (r_sel),
        .dec_err_o      (dec_err)
    );

    // ==============================
    // Region RAMs
    // ==============================
    region_ram #(.ADDR_W(REGION0_WORD_AW)) u_region0 (  // 4 KB
        .clk        (clk),
        .rst_n      (rst_n),
        .stb_i      (r0_stb),
        .we_i       (r_we),
        .word_adr_i (r_word_adr),
        .dat_i      (r_dat),
        .sel_i      (r_sel),
        .ack_o      (r0_ack),
        .rdata_o    (r0_rdata)
    );

    region_ram #(.ADDR_W(REGION1_WORD_AW)) u_region1 (  // 64 KB
        .clk        (clk),
        .rst_n      (rst_n),
        .stb_i      (r1_stb),
        .we_i       (r_we),
        .word_adr_i (r_word_adr),
        .dat_i      (r_dat),
        .sel_i      (r_sel),
        .ack_o      (r1_ack),
        .rdata_o    (r1_rdata)
    );

    // Second cycle of latency
    response_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .r0_ack_i   (r0_ack),
        .r0_rdata_i (r0_rdata),
        .r1_ack_i   (r1_ack),
        .r1_rdata_i (r1_rdata),
        .dec_err_i  (dec_err),
        .ack_o      (ack_o),
        .err_o      (err_o),
        .dat_o      (dat_o)
    );

endmodule : data_mem_subsystem

`default_nettype wire

//--- data_stim.txt
// Columns, hex: op adr wdata sel kind rdata
// op 0 idle, 1 write, 2 read, 3 set bases (adr = Region 0, wdata = Region 1), FF end
// kind 0 none, 1 ack, 2 err; rdata is checked on reads only
03 00000000 00001000 0 0 00000000
00 00000000 00000000 0 0 00000000
00 00000000 00000000 0 0 00000000
00 00000000 00000000 0 0 00000000
// Region 0 full word
01 00000010 11223344 F 1 00000000
02 00000010 00000000 F 1 11223344
00 00000000 00000000 0 0 00000000
// Region 1 last word
01 00010FFC A5A55A5A F 1 00000000
02 00010FFC 00000000 F 1 A5A55A5A
// Region 1 byte lanes 0 and 2
01 00001020 DEADBEEF F 1 00000000
02 00001020 00000000 F 1 DEADBEEF
01 00001020 12345678 5 1 00000000
02 00001020 00000000 F 1 DE34BE78
00 00000000 00000000 0 0 00000000
// Just past the end of Region 1
02 00011000 00000000 F 2 00000000
01 00011000 55555555 F 2 00000000
00 00000000 00000000 0 0 00000000
// Back to back, alternating regions
01 00000020 01010101 F 1 00000000
01 00001040 02020202 F 1 00000000
01 00000024 03030303 F 1 00000000
01 00001044 04040404 F 1 00000000
02 00000020 00000000 F 1 01010101
02 00001040 00000000 F 1 02020202
02 00011004 00000000 F 2 00000000
02 00000024 00000000 F 1 03030303
02 00001044 00000000 F 1 04040404
00 00000000 00000000 0 0 00000000
00 00000000 00000000 0 0 00000000
// Move both windows, gap below Region 0
03 00004000 00020000 0 0 00000000
02 00003000 00000000 F 2 00000000
02 00001000 00000000 F 2 00000000
02 00020020 00000000 F 1 DE34BE78
02 00004010 00000000 F 1 11223344
02 0002FFFC 00000000 F 1 A5A55A5A
02 00030000 00000000 F 2 00000000
02 00000000 00000000 F 2 00000000
02 00020040 00000000 F 1 02020202
01 00020000 CAFEF00D F 1 00000000
02 00020000 00000000 F 1 CAFEF00D
00 00000000 00000000 0 0 00000000
// Overlapping windows, Region 0 wins
03 00001000 00000000 0 0 00000000
02 00001010 00000000 F 1 11223344
02 00000020 00000000 F 1 DE34BE78
02 00001024 00000000 F 1 03030303
02 00000000 00000000 F 1 CAFEF00D
02 0000FFFC 00000000 F 1 A5A55A5A
02 00010000 00000000 F 2 00000000
00 00000000 00000000 0 0 00000000
00 00000000 00000000 0 0 00000000
00 00000000 00000000 0 0 00000000
FF 00000000 00000000 0 0 00000000

//--- mem_map_pkg.sv
// Data memory map
`default_nettype none

package mem_map_pkg;

    // ==============================
    // Region sizes in bytes
    // ==============================
    localparam int unsigned REGION0_BYTES = 4096;   // 4 KB, 1K words
    localparam int unsigned REGION1_BYTES = 65536;  // 64 KB, 16K words

    // Word-address widths follow from the sizes
    localparam int REGION0_WORD_AW = $clog2(REGION0_BYTES / 4); // 10
    localparam int REGION1_WORD_AW = $clog2(REGION1_BYTES / 4); // 14

    // ==============================
    // Reset-time bases
    // ==============================
    localparam logic [31:0] REGION0_BASE_DEFAULT = 32'h0000_0000;
    localparam logic [31:0] REGION1_BASE_DEFAULT = 32'h0000_1000; // Right after Region 0

    // Strobe to ack_o or err_o, in cycles
    localparam int RESP_LATENCY = 2;

endpackage : mem_map_pkg

`default_nettype wire

//--- project.f
wb_pkg.sv
mem_map_pkg.sv
region_decoder.sv
region_ram.sv
response_merge.sv
data_mem_subsystem.sv
tb_data_mem.sv

//--- region_decoder.sv
// Data port address decoder
`timescale 1ns/1ps
`default_nettype none

module region_decoder (
    input  logic              clk,
    input  logic              rst_n,
    // Request from the bus master
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  wb_pkg::wb_addr_t  adr_i,
    input  wb_pkg::wb_data_t  dat_i,
    input  wb_pkg::wb_sel_t   sel_i,
    // Run-time window bases, stable while cyc_i is high
    input  wb_pkg::wb_addr_t  region0_base_i,
    input  wb_pkg::wb_addr_t  region1_base_i,
    // Shared request lines to both RAMs
    output logic              r0_stb_o,
    output logic              r1_stb_o,
    output logic              r_we_o,
    output wb_pkg::wb_addr_t  r_word_adr_o,
    output wb_pkg::wb_data_t  r_dat_o,
    output wb_pkg::wb_sel_t   r_sel_o,
    // Unmapped access, one cycle late
    output logic              dec_err_o
);
    import wb_pkg::*;
    import mem_map_pkg::*;

    // ==============================
    // Window compare
    // ==============================
    wb_addr_t off0;       // Byte offset into Region 0
    wb_addr_t off1;       // Byte offset into Region 1
    logic     req;        // Accepted request this cycle
    logic     hit0;
    logic     hit1;
    logic     dec_err_q;

    assign req  = cyc_i & stb_i;  // No stall, so every strobe is taken
    assign off0 = adr_i - region0_base_i;
    assign off1 = adr_i - region1_base_i;

    // Offset test avoids overflow of base + size near the top of the space
    assign hit0 = (adr_i >= region0_base_i) && (off0 < REGION0_BYTES);
    assign hit1 = (adr_i >= region1_base_i) && (off1 < REGION1_BYTES);

    // ==============================
    // Routing
    // ==============================
    // Region 0 has priority on overlap
    assign r0_stb_o = req & hit0;
    assign r1_stb_o = req & ~hit0 & hit1;

    // Local word address of the winning window
    assign r_word_adr_o = hit0 ? (off0 >> 2) : (off1 >> 2);

    assign r_we_o  = we_i;   // Only the strobed RAM acts on these
    assign r_dat_o = dat_i;
    assign r_sel_o = sel_i;

    // Error pulse lines up with the RAM acks
    always_ff @(posedge clk) begin
        if (rst_n) begin
            dec_err_q <= 1'b0;
        end else begin
            dec_err_q <= req & ~hit0 & ~hit1;
        end
    end

    assign dec_err_o = dec_err_q;

    // Bases move only between bus cycles
    assert property (@(posedge clk) disable iff (rst_n)
        cyc_i |-> ($stable(region0_base_i) && $stable(region1_base_i)))
        else $error("Window base changed during a bus cycle");

endmodule : region_decoder

`default_nettype wire

//--- region_ram.sv
// Byte-writable region RAM
`timescale 1ns/1ps
`default_nettype none

module region_ram #(
    parameter int ADDR_W = 10              // Log2 of depth in words
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stb_i,       // Request for this region
    input  logic              we_i,
    input  wb_pkg::wb_addr_t  word_adr_i,  // Local word address from the decoder
    input  wb_pkg::wb_data_t  dat_i,
    input  wb_pkg::wb_sel_t   sel_i,
    output logic              ack_o,
    output wb_pkg::wb_data_t  rdata_o
);
    import wb_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    // ==============================
    // Storage
    // ==============================
    wb_data_t          mem [DEPTH];
    wb_data_t          rdata_q;    // Last word read
    logic [ADDR_W-1:0] idx;        // Row index
    logic              ack_q;

    assign idx = word_adr_i[ADDR_W-1:0];

    // Write only the enabled lanes
    always_ff @(posedge clk) begin
        if (stb_i && we_i) begin
            for (int i = 0; i < WB_SEL_W; i++) begin
                if (sel_i[i]) begin
                    mem[idx][8*i +: 8] <= dat_i[8*i +: 8];
                end
            end
        end
    end

    // Registered read, held until the next read
    always_ff @(posedge clk) begin
        if (stb_i && !we_i) begin
            rdata_q <= mem[idx];
        end
    end

    // ==============================
    // Handshake
    // ==============================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i;  // One response per strobe, reads and writes
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

    // Decoder must keep the local address inside this RAM
    assert property (@(posedge clk) disable iff (rst_n)
        stb_i |-> ((word_adr_i >> ADDR_W) == '0))
        else $error("Word address beyond region depth");

endmodule : region_ram

`default_nettype wire

//--- response_merge.sv
// Response merge stage
`timescale 1ns/1ps
`default_nettype none

module response_merge (
    input  logic              clk,
    input  logic              rst_n,
    // Region 0 response
    input  logic              r0_ack_i,
    input  wb_pkg::wb_data_t  r0_rdata_i,
    // Region 1 response
    input  logic              r1_ack_i,
    input  wb_pkg::wb_data_t  r1_rdata_i,
    // Unmapped access from the decoder
    input  logic              dec_err_i,
    // Merged response to the master
    output logic              ack_o,
    output logic              err_o,
    output wb_pkg::wb_data_t  dat_o
);
    import wb_pkg::*;

    // ==============================
    // Output registers
    // ==============================
    logic     ack_q;
    logic     err_q;
    wb_data_t dat_q;      // Held between responses
    wb_data_t sel_data;   // Data of the acking region

    assign sel_data = r0_ack_i ? r0_rdata_i : r1_rdata_i;

    // Control bits, cleared on reset
    always_ff @(posedge clk) begin
        if (rst_n) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= r0_ack_i | r1_ack_i;
            err_q <= dec_err_i;
        end
    end

    // Capture data only on an ack
    always_ff @(posedge clk) begin
        if (r0_ack_i || r1_ack_i) begin
            dat_q <= sel_data;
        end
    end

    assign ack_o = ack_q;
    assign err_o = err_q;
    assign dat_o = dat_q;

    // Decoder sends each request to one place, so responses never collide
    assert property (@(posedge clk) disable iff (rst_n)
        $onehot0({r0_ack_i, r1_ack_i, dec_err_i}))
        else $error("Two responses in one cycle");

endmodule : response_merge

`default_nettype wire

//--- tb_data_mem.sv
// Data memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem;
    import wb_pkg::*;
    import mem_map_pkg::*;

    // ==============================
    // Constants
    // ==============================
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_LINES    = 96;    // Capacity of the stimulus array
    localparam int FIELDS       = 6;     // op adr wdata sel kind rdata

    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_READ  = 32'h2;
    localparam logic [31:0] OP_BASES = 32'h3;   // adr and wdata carry the new bases
    localparam logic [31:0] OP_END   = 32'hFF;
    localparam logic [31:0] KIND_ACK = 32'h1;

    // DUT side
    logic     clk;
    logic     rst_n;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t wdata;
    wb_sel_t  sel;
    wb_addr_t region0_base;
    wb_addr_t region1_base;
    logic     ack;
    logic     err;
    wb_data_t rdata;

    // Stimulus and expectations
    logic [31:0] stim_mem [MAX_LINES*FIELDS];
    int          n_lines;
    int unsigned cycle = 0;          // Rising edges so far
    int unsigned cycle_limit = 0;    // Zero until the stimulus is loaded
    logic [31:0] exp_kind_q [$];
    logic [31:0] exp_data_q [$];
    logic        exp_read_q [$];
    int unsigned exp_due_q  [$];     // Cycle in which the response must show
    int          exp_line_q [$];

    data_mem_subsystem i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .cyc_i          (cyc),
        .stb_i          (stb),
        .we_i           (we),
        .adr_i          (adr),
        .dat_i          (wdata),
        .sel_i          (sel),
        .ack_o          (ack),
        .err_o          (err),
        .dat_o          (rdata),
        .region0_base_i (region0_base),
        .region1_base_i (region1_base)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Failure reporting
    // ==============================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Cycle counter and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit != 0 && cycle >= cycle_limit) begin
            abort_run($sformatf("Timeout: run still busy after %0d cycles", cycle));
        end
    end

    // ==============================
    // Driver
    // ==============================
    task automatic drive_line(input int line);
        logic [31:0] op;
        logic [31:0] f_adr;
        logic [31:0] f_wdata;
        logic [31:0] f_sel;
        logic [31:0] f_kind;
        logic [31:0] f_rdata;
        op      = stim_mem[line*FIELDS + 0];
        f_adr   = stim_mem[line*FIELDS + 1];
        f_wdata = stim_mem[line*FIELDS + 2];
        f_sel   = stim_mem[line*FIELDS + 3];
        f_kind  = stim_mem[line*FIELDS + 4];
        f_rdata = stim_mem[line*FIELDS + 5];
        cyc = 1'b0;    // Idle unless the line says otherwise
        stb = 1'b0;
        we  = 1'b0;
        if (op == OP_WRITE || op == OP_READ) begin
            cyc   = 1'b1;
            stb   = 1'b1;
            we    = (op == OP_WRITE);
            adr   = f_adr;
            wdata = f_wdata;
            sel   = f_sel[WB_SEL_W-1:0];
            exp_kind_q.push_back(f_kind);
            exp_data_q.push_back(f_rdata);
            exp_read_q.push_back(op == OP_READ);
            exp_due_q.push_back(cycle + RESP_LATENCY);  // Strobe cycle plus latency
            exp_line_q.push_back(line);
        end else if (op == OP_BASES) begin
            region0_base = f_adr;     // cyc is low here
            region1_base = f_wdata;
        end
    endtask

    // ==============================
    // Response monitor
    // ==============================
    task automatic check_response();
        logic [31:0] kind;
        logic [31:0] data;
        logic        is_read;
        int unsigned due;
        int          line;
        if (ack && err) begin
            abort_run("ack_o and err_o were high in the same cycle");
        end else if (ack || err) begin
            if (exp_kind_q.size() == 0) begin
                abort_run("A response arrived with no request outstanding");
            end else begin
                kind    = exp_kind_q.pop_front();
                data    = exp_data_q.pop_front();
                is_read = exp_read_q.pop_front();
                due     = exp_due_q.pop_front();
                line    = exp_line_q.pop_front();
                check_value($sformatf("response cycle (entry %0d)", line), cycle, due);
                check_value($sformatf("ack_o (entry %0d)", line),
                            {31'b0, ack}, {31'b0, kind == KIND_ACK});
                check_value($sformatf("err_o (entry %0d)", line),
                            {31'b0, err}, {31'b0, kind != KIND_ACK});
                if (is_read && ack) begin
                    check_value($sformatf("dat_o (entry %0d)", line), rdata, data);
                end
            end
        end else if (exp_due_q.size() != 0 && exp_due_q[0] < cycle) begin
            abort_run($sformatf("No response for stimulus entry %0d", exp_line_q[0]));
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin    // Out of reset
            check_response();
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n        = 1'b1;   // Reset is active high
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        wdata        = '0;
        sel          = '0;
        region0_base = REGION0_BASE_DEFAULT;
        region1_base = REGION1_BASE_DEFAULT;

        $readmemh("data_stim.txt", stim_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && stim_mem[n_lines*FIELDS] != OP_END) begin
            n_lines++;
        end
        cycle_limit = n_lines * 4 + 50;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b0;

        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            #1;
            drive_line(i);
        end
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;

        // Drain what is still in flight
        while (exp_kind_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);   // Room for a stray response

        if (n_lines > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("No stimulus entries were loaded from data_stim.txt");
        end
    end

endmodule : tb_data_mem

`default_nettype wire

//--- wb_pkg.sv
// Wishbone data port definitions
`default_nettype none

package wb_pkg;

    // ==============================
    // Bus widths
    // ==============================
    localparam int WB_ADDR_W = 32;            // Byte address width
    localparam int WB_DATA_W = 32;            // One data word
    localparam int WB_SEL_W  = WB_DATA_W / 8; // Byte lanes per word

    // ==============================
    // Bus types
    // ==============================
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;  // Byte address
    typedef logic [WB_DATA_W-1:0] wb_data_t;  // Data word
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;   // Byte-enable mask, bit i is lane i

    // Lane i covers data bits [8*i+7:8*i]

endpackage : wb_pkg

`default_nettype wire
